//--- files.f
logic/usb_pkg.sv
logic/usb_packet_decoder.sv
logic/usb_std_request.sv
logic/usb_ctrl_pipe.sv
logic/usb_ctrl_top.sv
verif/tb_usb_ctrl.sv

//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = tb_usb_ctrl
RTL_TOP    = usb_ctrl_top
FILELIST   = files.f
BUILD_DIR  = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- verif/tb_usb_ctrl.sv
`default_nettype none

module tb_usb_ctrl;

  timeunit 1ns;
  timeprecision 100ps;

  import usb_pkg::*;

  localparam int num_rows    = 11;
  // Worst case per row is about 60 cycles with the largest idle gaps
  localparam int row_budget  = 100;
  localparam int cycle_limit = num_rows * row_budget + 20;
  localparam int drive_dly   = 5;

  // Which PID of a row is corrupted
  localparam logic [1:0] bad_none  = 2'd0;
  localparam logic [1:0] bad_token = 2'd1;
  localparam logic [1:0] bad_data  = 2'd2;

  // One control transfer per row with setup byte 0 in the top byte
  typedef struct packed {
    logic [6:0]  addr;
    logic [3:0]  endp;
    logic [3:0]  pid;
    logic [63:0] setup;
    logic [1:0]  bad;
    logic        dir_in;
    logic        end_tmo;
    logic        exp_start;
    logic [6:0]  exp_addr;
    logic        exp_cfg;
  } row_t;

  logic        clock;
  logic        reset;
  logic        rx_valid_i;
  logic        rx_last_i;
  logic [7:0]  rx_data_i;
  logic        hsk_sent_i;
  logic        timeout_i;
  logic        start_o;
  logic        select_o;
  logic        status_o;
  logic        parity_o;
  logic        finish_o;
  logic        req_start_o;
  logic [7:0]  req_rtype_o;
  logic [7:0]  req_rargs_o;
  logic [15:0] req_value_o;
  logic [15:0] req_index_o;
  logic [15:0] req_length_o;
  logic [6:0]  usb_addr_o;
  logic        configured_o;

  row_t        rows [num_rows];
  logic [31:0] rng = 32'd71211;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  // Strobe counts of the current row
  int          n_start = 0;
  int          n_status = 0;
  int          n_finish = 0;
  int          n_req = 0;
  logic        sel_seen = 1'b0;

  usb_ctrl_top uut (
    .clock        (clock),
    .reset        (reset),
    .rx_valid_i   (rx_valid_i),
    .rx_last_i    (rx_last_i),
    .rx_data_i    (rx_data_i),
    .hsk_sent_i   (hsk_sent_i),
    .timeout_i    (timeout_i),
    .start_o      (start_o),
    .select_o     (select_o),
    .status_o     (status_o),
    .parity_o     (parity_o),
    .finish_o     (finish_o),
    .req_start_o  (req_start_o),
    .req_rtype_o  (req_rtype_o),
    .req_rargs_o  (req_rargs_o),
    .req_value_o  (req_value_o),
    .req_index_o  (req_index_o),
    .req_length_o (req_length_o),
    .usb_addr_o   (usb_addr_o),
    .configured_o (configured_o)
  );

  always #20 clock = ~clock;

  // Run limit
  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  // Strobes sampled mid-cycle away from the clock edge
  always @(negedge clock) begin
    if (!reset) begin
      if (start_o) n_start++;
      if (status_o) n_status++;
      if (finish_o) n_finish++;
      if (req_start_o) n_req++;
      if (select_o) sel_seen = 1'b1;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] setup_byte(input logic [63:0] s, input int k);
    return s[63-8*k -: 8];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // Next drive point a little after the rising edge
  task automatic step();
    @(posedge clock);
    #drive_dly;
  endtask

  // Zero to two idle cycles
  task automatic idle_gap();
    rng = xorshift32(rng);
    repeat (rng % 3) step();
  endtask

  task automatic send_byte(input logic [7:0] b, input logic last);
    rx_valid_i = 1'b1;
    rx_data_i  = b;
    rx_last_i  = last;
    step();
    rx_valid_i = 1'b0;
    rx_last_i  = 1'b0;
  endtask

  // Upper nibble is the complement with bit 7 flipped when corrupted
  function automatic logic [7:0] pid_byte(input logic [3:0] pid, input logic corrupt);
    return {~pid ^ {corrupt, 3'b000}, pid};
  endfunction

  task automatic send_token(input logic [3:0] pid, input logic [6:0] addr,
                            input logic [3:0] endp, input logic corrupt);
    send_byte(pid_byte(pid, corrupt), 1'b0);
    idle_gap();
    send_byte({endp[0], addr}, 1'b0);
    idle_gap();
    rng = xorshift32(rng);
    // Dummy CRC5 in the upper bits
    send_byte({rng[4:0], endp[3:1]}, 1'b1);
  endtask

  task automatic send_data(input logic [63:0] setup, input logic corrupt);
    send_byte(pid_byte(pid_data0, corrupt), 1'b0);
    for (int k = 0; k < setup_bytes; k++) begin
      idle_gap();
      send_byte(setup_byte(setup, k), 1'b0);
    end
    // Dummy CRC16
    rng = xorshift32(rng);
    idle_gap();
    send_byte(rng[7:0], 1'b0);
    idle_gap();
    send_byte(rng[15:8], 1'b1);
  endtask

  task automatic pulse_input(input logic tmo);
    if (tmo) timeout_i = 1'b1;
    else hsk_sent_i = 1'b1;
    step();
    timeout_i  = 1'b0;
    hsk_sent_i = 1'b0;
  endtask

  // Handshake of the data or status stage with a host ACK for IN
  task automatic end_stage(input logic dir_in);
    if (dir_in) begin
      send_byte(pid_byte(pid_ack, 1'b0), 1'b1);
      step();
    end else begin
      pulse_input(1'b0);
    end
  endtask

  task automatic load_table();
    // GET_DESCRIPTOR with an IN data stage
    rows[0]  = '{7'h00, 4'h0, pid_setup, 64'h8006_0001_0000_1200, bad_none,
                 1'b1, 1'b0, 1'b1, 7'h00, 1'b0};
    // Zero-length SET_ADDRESS 0x2a
    rows[1]  = '{7'h00, 4'h0, pid_setup, 64'h0005_2a00_0000_0000, bad_none,
                 1'b0, 1'b0, 1'b1, 7'h2a, 1'b0};
    // Rejected by old address, endpoint 1, IN token and bad token PID
    rows[2]  = '{7'h00, 4'h0, pid_setup, 64'h0009_0100_0000_0000, bad_none,
                 1'b0, 1'b0, 1'b0, 7'h2a, 1'b0};
    rows[3]  = '{7'h2a, 4'h1, pid_setup, 64'h0009_0100_0000_0000, bad_none,
                 1'b0, 1'b0, 1'b0, 7'h2a, 1'b0};
    rows[4]  = '{7'h2a, 4'h0, pid_in, 64'h0009_0100_0000_0000, bad_none,
                 1'b0, 1'b0, 1'b0, 7'h2a, 1'b0};
    rows[5]  = '{7'h2a, 4'h0, pid_setup, 64'h0009_0100_0000_0000, bad_token,
                 1'b0, 1'b0, 1'b0, 7'h2a, 1'b0};
    // SET_CONFIGURATION 1 whose status stage times out
    rows[6]  = '{7'h2a, 4'h0, pid_setup, 64'h0009_0100_0000_0000, bad_none,
                 1'b0, 1'b1, 1'b1, 7'h2a, 1'b1};
    // Corrupt DATA0 so the setup stage ends in a timeout
    rows[7]  = '{7'h2a, 4'h0, pid_setup, 64'h0009_0000_0000_0000, bad_data,
                 1'b0, 1'b1, 1'b1, 7'h2a, 1'b1};
    // SET_DESCRIPTOR with an OUT data stage
    rows[8]  = '{7'h2a, 4'h0, pid_setup, 64'h0007_0001_0000_0400, bad_none,
                 1'b0, 1'b0, 1'b1, 7'h2a, 1'b1};
    // GET_STATUS
    rows[9]  = '{7'h2a, 4'h0, pid_setup, 64'h8000_0000_0000_0200, bad_none,
                 1'b1, 1'b0, 1'b1, 7'h2a, 1'b1};
    // SET_CONFIGURATION 0 deconfigures
    rows[10] = '{7'h2a, 4'h0, pid_setup, 64'h0009_0000_0000_0000, bad_none,
                 1'b0, 1'b0, 1'b1, 7'h2a, 1'b0};
  endtask

  task automatic run_row(input int idx);
    row_t        r;
    logic [15:0] length;
    logic        zero_len;
    logic        good;
    int          err0;
    r        = rows[idx];
    length   = {setup_byte(r.setup, 7), setup_byte(r.setup, 6)};
    zero_len = (length == 16'h0000);
    good     = r.exp_start && (r.bad != bad_data);
    err0     = errors;
    n_start  = 0;
    n_status = 0;
    n_finish = 0;
    n_req    = 0;
    sel_seen = 1'b0;
    // start_o two cycles after the last token byte
    send_token(r.pid, r.addr, r.endp, r.bad == bad_token);
    check_value("start_o", start_o, 1'b0);
    step();
    check_value("start_o", start_o, r.exp_start);
    check_value("select_o", select_o, r.exp_start);
    idle_gap();
    send_data(r.setup, r.bad == bad_data);
    check_value("req_start_o", req_start_o, 1'b0);
    step();
    check_value("req_start_o", req_start_o, good);
    if (good) begin
      check_value("req_rtype_o", req_rtype_o, setup_byte(r.setup, 0));
      check_value("req_rargs_o", req_rargs_o, setup_byte(r.setup, 1));
      check_value("req_value_o", req_value_o,
                  {setup_byte(r.setup, 3), setup_byte(r.setup, 2)});
      check_value("req_index_o", req_index_o,
                  {setup_byte(r.setup, 5), setup_byte(r.setup, 4)});
      check_value("req_length_o", req_length_o, length);
      // Data toggle stays even until the setup ACK
      check_value("parity_o", parity_o, 1'b0);
      // Setup ACK sent by the device
      idle_gap();
      pulse_input(1'b0);
      check_value("status_o", status_o, zero_len);
      check_value("parity_o", parity_o, 1'b1);
      if (!zero_len) begin
        idle_gap();
        end_stage(r.dir_in);
        // Data toggle flips and OUT gets a zero-length status
        check_value("parity_o", parity_o, 1'b0);
        check_value("status_o", status_o, !r.dir_in);
      end
      step();
      check_value("parity_o", parity_o, 1'b1);
      check_value("select_o", select_o, 1'b1);
      idle_gap();
      if (r.end_tmo) pulse_input(1'b1);
      else end_stage(r.dir_in);
      check_value("finish_o", finish_o, 1'b1);
      check_value("select_o", select_o, 1'b0);
    end else if (r.exp_start) begin
      // Setup stage dropped on timeout
      check_value("select_o", select_o, 1'b1);
      pulse_input(1'b1);
      check_value("select_o", select_o, 1'b0);
    end
    // New address and configuration settle after the transfer
    repeat (3) step();
    check_value("start_o pulses", n_start, r.exp_start);
    check_value("req_start_o pulses", n_req, good);
    check_value("finish_o pulses", n_finish, good);
    check_value("status_o pulses", n_status, good && (zero_len || !r.dir_in));
    check_value("select_o seen", sel_seen, r.exp_start);
    check_value("select_o", select_o, 1'b0);
    check_value("parity_o", parity_o, 1'b0);
    check_value("usb_addr_o", usb_addr_o, r.exp_addr);
    check_value("configured_o", configured_o, r.exp_cfg);
    $display("row %0d %s, %0d errors", idx, (errors == err0) ? "ok" : "failed",
             errors - err0);
  endtask

  initial begin
    clock      = 1'b0;
    reset      = 1'b1;
    rx_valid_i = 1'b0;
    rx_last_i  = 1'b0;
    rx_data_i  = 8'h00;
    hsk_sent_i = 1'b0;
    timeout_i  = 1'b0;
    load_table();
    repeat (4) @(posedge clock);
    #drive_dly;
    reset = 1'b0;
    step();
    // State right after reset
    check_value("start_o", start_o, 1'b0);
    check_value("status_o", status_o, 1'b0);
    check_value("finish_o", finish_o, 1'b0);
    check_value("req_start_o", req_start_o, 1'b0);
    check_value("select_o", select_o, 1'b0);
    check_value("parity_o", parity_o, 1'b0);
    check_value("usb_addr_o", usb_addr_o, 7'h00);
    check_value("configured_o", configured_o, 1'b0);
    for (int i = 0; i < num_rows; i++) begin
      run_row(i);
    end
    $display("rows %0d, checks %0d, errors %0d", num_rows, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/usb_ctrl_top.sv
`default_nettype none

module usb_ctrl_top (
  input  logic        clock,
  input  logic        reset,
  input  logic        rx_valid_i,
  input  logic        rx_last_i,
  input  logic [7:0]  rx_data_i,
  input  logic        hsk_sent_i,
  input  logic        timeout_i,
  output logic        start_o,
  output logic        select_o,
  output logic        status_o,
  output logic        parity_o,
  output logic        finish_o,
  output logic        req_start_o,
  output logic [7:0]  req_rtype_o,
  output logic [7:0]  req_rargs_o,
  output logic [15:0] req_value_o,
  output logic [15:0] req_index_o,
  output logic [15:0] req_length_o,
  output logic [6:0]  usb_addr_o,
  output logic        configured_o
);

  // Decoder outputs
  logic       tok_recv;
  logic [6:0] tok_addr;
  logic [3:0] tok_endp;
  logic [3:0] pid_last;
  logic       hsk_recv;
  logic       pay_valid;
  logic [7:0] pay_data;

  // Request cycle to the control pipe
  logic       req_cycle;

  usb_packet_decoder u_decoder (
    .clock       (clock),
    .reset       (reset),
    .rx_valid_i  (rx_valid_i),
    .rx_last_i   (rx_last_i),
    .rx_data_i   (rx_data_i),
    .tok_recv_o  (tok_recv),
    .tok_addr_o  (tok_addr),
    .tok_endp_o  (tok_endp),
    .pid_last_o  (pid_last),
    .hsk_recv_o  (hsk_recv),
    .pay_valid_o (pay_valid),
    .pay_data_o  (pay_data)
  );

  // Control requests on endpoint 0 only
  usb_std_request #(
    .ep0_only (1'b1)
  ) u_std_request (
    .clock        (clock),
    .reset        (reset),
    .usb_addr_i   (usb_addr_o),
    .tok_recv_i   (tok_recv),
    .tok_addr_i   (tok_addr),
    .tok_endp_i   (tok_endp),
    .pid_last_i   (pid_last),
    .hsk_recv_i   (hsk_recv),
    .hsk_sent_i   (hsk_sent_i),
    .timeout_i    (timeout_i),
    .pay_valid_i  (pay_valid),
    .pay_data_i   (pay_data),
    .start_o      (start_o),
    .select_o     (select_o),
    .status_o     (status_o),
    .parity_o     (parity_o),
    .finish_o     (finish_o),
    .req_start_o  (req_start_o),
    .req_cycle_o  (req_cycle),
    .req_rtype_o  (req_rtype_o),
    .req_rargs_o  (req_rargs_o),
    .req_value_o  (req_value_o),
    .req_index_o  (req_index_o),
    .req_length_o (req_length_o)
  );

  usb_ctrl_pipe u_ctrl_pipe (
    .clock        (clock),
    .reset        (reset),
    .req_start_i  (req_start_o),
    .req_cycle_i  (req_cycle),
    .req_rargs_i  (req_rargs_o),
    .req_value_i  (req_value_o),
    .usb_addr_o   (usb_addr_o),
    .configured_o (configured_o)
  );

endmodule

`default_nettype wire

//--- logic/usb_ctrl_pipe.sv
`default_nettype none

module usb_ctrl_pipe (
  input  logic        clock,
  input  logic        reset,
  input  logic        req_start_i,
  input  logic        req_cycle_i,
  input  logic [7:0]  req_rargs_i,
  input  logic [15:0] req_value_i,
  output logic [6:0]  usb_addr_o,
  output logic        configured_o
);

  import usb_pkg::*;

  // Pending changes wait for the end of the transfer
  logic [6:0] addr_pend_q;
  logic [7:0] cfg_pend_q;
  logic       addr_upd_q;
  logic       cfg_upd_q;
  logic [7:0] cfg_q;
  logic       cycle_d_q;
  logic       cycle_fall;

  // Status stage done when the request cycle drops
  assign cycle_fall = cycle_d_q && !req_cycle_i;

  assign configured_o = (cfg_q != 8'h00);

  always_ff @(posedge clock) begin
    if (reset) begin
      cycle_d_q  <= 1'b0;
      addr_upd_q <= 1'b0;
      cfg_upd_q  <= 1'b0;
      usb_addr_o <= 7'h00;
      cfg_q      <= 8'h00;
    end else begin
      cycle_d_q <= req_cycle_i;
      if (req_start_i) begin
        // Any other request leaves the state alone
        addr_upd_q <= (req_rargs_i == req_set_address);
        cfg_upd_q  <= (req_rargs_i == req_set_configuration);
      end else if (cycle_fall) begin
        if (addr_upd_q) begin
          usb_addr_o <= addr_pend_q;
        end
        if (cfg_upd_q) begin
          cfg_q <= cfg_pend_q;
        end
        addr_upd_q <= 1'b0;
        cfg_upd_q  <= 1'b0;
      end
    end
  end

  // New address is wValue[6:0], configuration is wValue[7:0]
  always_ff @(posedge clock) begin
    if (req_start_i) begin
      addr_pend_q <= req_value_i[6:0];
      cfg_pend_q  <= req_value_i[7:0];
    end
  end

endmodule

`default_nettype wire

//--- logic/usb_std_request.sv
`default_nettype none

module usb_std_request #(
  parameter bit ep0_only = 1'b1
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [6:0]  usb_addr_i,
  input  logic        tok_recv_i,
  input  logic [6:0]  tok_addr_i,
  input  logic [3:0]  tok_endp_i,
  input  logic [3:0]  pid_last_i,
  input  logic        hsk_recv_i,
  input  logic        hsk_sent_i,
  input  logic        timeout_i,
  input  logic        pay_valid_i,
  input  logic [7:0]  pay_data_i,
  output logic        start_o,
  output logic        select_o,
  output logic        status_o,
  output logic        parity_o,
  output logic        finish_o,
  output logic        req_start_o,
  output logic        req_cycle_o,
  output logic [7:0]  req_rtype_o,
  output logic [7:0]  req_rargs_o,
  output logic [15:0] req_value_o,
  output logic [15:0] req_index_o,
  output logic [15:0] req_length_o
);

  import usb_pkg::*;

  logic [3:0] stage_q;
  logic [3:0] stage_d;
  logic       zdp_d;
  logic       abort_d;

  // Setup byte pointer, one extra bit marks all bytes taken
  logic [$clog2(setup_bytes):0] ptr_q;
  logic [7:0] req_bytes_q [setup_bytes];

  logic sel_w;
  logic req_w;
  logic end_w;
  logic zero_len;
  logic data_ack_w;

  // Request fields, multi-byte values little-endian
  assign req_rtype_o  = req_bytes_q[0];
  assign req_rargs_o  = req_bytes_q[1];
  assign req_value_o  = {req_bytes_q[3], req_bytes_q[2]};
  assign req_index_o  = {req_bytes_q[5], req_bytes_q[4]};
  assign req_length_o = {req_bytes_q[7], req_bytes_q[6]};

  assign zero_len = (req_length_o == 16'h0000);

  // SETUP token aimed at this device
  assign sel_w = (stage_q == stage_idle) && tok_recv_i && (tok_addr_i == usb_addr_i) &&
                 (pid_last_i == pid_setup) && (!ep0_only || tok_endp_i == 4'h0);

  // DATA0 body of the setup stage carries the request
  assign req_w = (stage_q == stage_setup) && (pid_last_i == pid_data0);

  // Status stage closes on any handshake or a timeout
  assign end_w = (stage_q == stage_status) && (hsk_sent_i || hsk_recv_i || timeout_i);

  // IN data is acked by the host, OUT data by us
  assign data_ack_w = req_rtype_o[7] ? hsk_recv_i : hsk_sent_i;

  // Stage machine next state
  always_comb begin
    stage_d = stage_q;
    zdp_d   = 1'b0;
    abort_d = 1'b0;
    case (stage_q)
      stage_idle: begin
        if (sel_w) begin
          stage_d = stage_setup;
        end
      end
      stage_setup: begin
        if (hsk_sent_i) begin
          // No data stage for zero-length requests
          if (zero_len) begin
            stage_d = stage_status;
            zdp_d   = 1'b1;
          end else begin
            stage_d = stage_data;
          end
        end else if (timeout_i) begin
          stage_d = stage_idle;
          abort_d = 1'b1;
        end
      end
      stage_data: begin
        if (data_ack_w) begin
          stage_d = stage_status;
          // OUT request answers with a zero-length IN
          zdp_d   = ~req_rtype_o[7];
        end else if (timeout_i) begin
          stage_d = stage_idle;
          abort_d = 1'b1;
        end
      end
      stage_status: begin
        if (end_w) begin
          stage_d = stage_idle;
        end
      end
      default: stage_d = stage_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      stage_q  <= stage_idle;
      start_o  <= 1'b0;
      select_o <= 1'b0;
      status_o <= 1'b0;
      finish_o <= 1'b0;
      parity_o <= 1'b0;
    end else begin
      stage_q  <= stage_d;
      start_o  <= sel_w;
      status_o <= zdp_d;
      finish_o <= end_w;
      if (sel_w) begin
        select_o <= 1'b1;
      end else if (end_w || abort_d) begin
        select_o <= 1'b0;
      end
      // Data toggle, DATA1 follows the setup ACK
      case (stage_q)
        stage_idle:   parity_o <= 1'b0;
        stage_setup:  parity_o <= parity_o | hsk_sent_i;
        stage_data:   parity_o <= parity_o ^ (hsk_sent_i | hsk_recv_i);
        stage_status: parity_o <= 1'b1;
        default:      parity_o <= 1'b0;
      endcase
    end
  end

  // Setup byte parser control
  always_ff @(posedge clock) begin
    if (reset) begin
      ptr_q       <= '0;
      req_start_o <= 1'b0;
      req_cycle_o <= 1'b0;
    end else begin
      req_start_o <= 1'b0;
      if (sel_w) begin
        ptr_q <= '0;
      end else if (req_w && pay_valid_i && ptr_q < setup_bytes) begin
        ptr_q <= ptr_q + 1'b1;
        // Last request byte starts the request
        if (ptr_q == setup_bytes - 1) begin
          req_start_o <= 1'b1;
          req_cycle_o <= 1'b1;
        end
      end
      if (end_w || abort_d) begin
        req_cycle_o <= 1'b0;
      end
    end
  end

  // Request bytes, length cleared at each new transfer
  always_ff @(posedge clock) begin
    if (sel_w) begin
      req_bytes_q[6] <= 8'h00;
      req_bytes_q[7] <= 8'h00;
    end else if (req_w && pay_valid_i && ptr_q < setup_bytes) begin
      req_bytes_q[ptr_q[$clog2(setup_bytes)-1:0]] <= pay_data_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/usb_packet_decoder.sv
`default_nettype none

module usb_packet_decoder (
  input  logic       clock,
  input  logic       reset,
  input  logic       rx_valid_i,
  input  logic       rx_last_i,
  input  logic [7:0] rx_data_i,
  output logic       tok_recv_o,
  output logic [6:0] tok_addr_o,
  output logic [3:0] tok_endp_o,
  output logic [3:0] pid_last_o,
  output logic       hsk_recv_o,
  output logic       pay_valid_o,
  output logic [7:0] pay_data_o
);

  import usb_pkg::*;

  // Byte position in the packet, saturates at 3
  logic [1:0] pos_q;
  // Current packet passed its PID check and is a token / data packet
  logic       tok_q;
  logic       dat_q;
  // Two-byte delay line, holds back the CRC16
  logic [7:0] dly0_q;
  logic [7:0] dly1_q;

  logic [3:0] pid_nib;
  logic       pid_ok;
  logic       pid_tok;
  logic       pid_dat;
  logic       pid_hsk;

  assign pid_nib = rx_data_i[3:0];
  // Upper nibble must be the complement of the lower
  assign pid_ok  = (rx_data_i[7:4] == ~rx_data_i[3:0]);

  // Packet class from the PID nibble
  always_comb begin
    pid_tok = 1'b0;
    pid_dat = 1'b0;
    pid_hsk = 1'b0;
    case (pid_nib)
      pid_out, pid_in, pid_setup: pid_tok = 1'b1;
      pid_data0, pid_data1:       pid_dat = 1'b1;
      pid_ack, pid_nak, pid_stall: pid_hsk = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pos_q       <= 2'd0;
      tok_q       <= 1'b0;
      dat_q       <= 1'b0;
      pid_last_o  <= 4'h0;
      tok_recv_o  <= 1'b0;
      hsk_recv_o  <= 1'b0;
      pay_valid_o <= 1'b0;
    end else begin
      tok_recv_o  <= 1'b0;
      hsk_recv_o  <= 1'b0;
      pay_valid_o <= 1'b0;
      if (rx_valid_i) begin
        // Next byte after the last one is a PID again
        if (rx_last_i) begin
          pos_q <= 2'd0;
        end else if (pos_q != 2'd3) begin
          pos_q <= pos_q + 2'd1;
        end
        if (pos_q == 2'd0) begin
          // Failed check leaves both flags low, rest of packet ignored
          tok_q <= pid_ok && pid_tok;
          dat_q <= pid_ok && pid_dat;
          if (pid_ok) begin
            pid_last_o <= pid_nib;
          end
          // Only ACK is reported upward
          hsk_recv_o <= pid_ok && pid_hsk && (pid_nib == pid_ack);
        end else begin
          // Token complete after its second body byte, CRC5 ignored
          if (tok_q && pos_q == 2'd2) begin
            tok_recv_o <= 1'b1;
          end
          if (dat_q && pos_q == 2'd3) begin
            pay_valid_o <= 1'b1;
          end
        end
      end
    end
  end

  // Token fields and payload path
  always_ff @(posedge clock) begin
    if (rx_valid_i && pos_q != 2'd0) begin
      dly0_q <= rx_data_i;
      dly1_q <= dly0_q;
      // Emit byte k while byte k+2 arrives
      if (pos_q == 2'd3) begin
        pay_data_o <= dly1_q;
      end
      if (tok_q && pos_q == 2'd1) begin
        tok_addr_o    <= rx_data_i[6:0];
        tok_endp_o[0] <= rx_data_i[7];
      end
      // Endpoint straddles the byte boundary
      if (tok_q && pos_q == 2'd2) begin
        tok_endp_o[3:1] <= rx_data_i[2:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/usb_pkg.sv
`default_nettype none

package usb_pkg;

  // Token PID nibbles
  localparam logic [3:0] pid_out   = 4'b0001;
  localparam logic [3:0] pid_in    = 4'b1001;
  localparam logic [3:0] pid_setup = 4'b1101;

  // Data PID nibbles
  localparam logic [3:0] pid_data0 = 4'b0011;
  localparam logic [3:0] pid_data1 = 4'b1011;

  // Handshake PID nibbles
  localparam logic [3:0] pid_ack   = 4'b0010;
  localparam logic [3:0] pid_nak   = 4'b1010;
  localparam logic [3:0] pid_stall = 4'b1110;

  // Control-transfer stages, one-hot
  localparam logic [3:0] stage_idle   = 4'b0001;
  localparam logic [3:0] stage_setup  = 4'b0010;
  localparam logic [3:0] stage_data   = 4'b0100;
  localparam logic [3:0] stage_status = 4'b1000;

  // Standard request codes (bRequest)
  localparam logic [7:0] req_set_address       = 8'h05;
  localparam logic [7:0] req_set_configuration = 8'h09;

  // Bytes in the DATA0 body of a SETUP transaction
  localparam int unsigned setup_bytes = 8;

endpackage

`default_nettype wire
